/* Bender.yml */
package:
  name: lsu_pipe

sources:
  - common/rv32i_mem_pkg.sv
  - mem/mem_stage.sv
  - mem/data_sram.sv
  - hdl/wb_stage.sv
  - hdl/lsu_pipe_top.sv
  - target: simulation
    files:
      - sim/tb_lsu_pipe.sv

/* common/rv32i_mem_pkg.sv */
`default_nettype none

package rv32i_mem_pkg;

    // one data or address word
    typedef logic [31:0] rv32i_word;

    // memory class of the instruction in flight
    typedef enum logic [1:0] {
        mop_none  = 2'b00,
        mop_load  = 2'b01,
        mop_store = 2'b10
    } mem_op_e;

    // funct3 of the load opcode
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    // funct3 of the store opcode
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    // source of the value written back to the regfile
    typedef enum logic [2:0] {
        sel_alu      = 3'b000,
        sel_br_en    = 3'b001,
        sel_u_imm    = 3'b010,
        sel_pc_plus4 = 3'b011,
        sel_mem      = 3'b100
    } wb_sel_e;

    // rvfi style memory record
    // addr is word aligned, masks and data use the memory byte lanes
    typedef struct packed {
        rv32i_word  addr;
        logic [3:0] rmask;
        logic [3:0] wmask;
        rv32i_word  rdata;
        rv32i_word  wdata;
    } mem_rec_t;

    // execute result handed to the memory side
    typedef struct packed {
        mem_op_e    op;
        // raw funct3, read as load or store encoding depending on op
        logic [2:0] funct3;
        wb_sel_e    wb_sel;
        logic [4:0] rd;
        rv32i_word  pc;
        // alu result, also the effective address of a load or store
        rv32i_word  alu_out;
        // rs2 value, still in the low lanes
        rv32i_word  store_data;
        rv32i_word  u_imm;
        logic       br_en;
        mem_rec_t   mem;
    } ex_mem_t;

    // MEM/WB payload, load data comes straight from the sram
    typedef struct packed {
        wb_sel_e    wb_sel;
        logic [2:0] funct3;
        logic [4:0] rd;
        rv32i_word  pc;
        // non-load result
        rv32i_word  rd_data;
        // byte offset inside the word
        logic [1:0] offset;
        logic       misaligned;
        mem_rec_t   mem;
    } mem_wb_t;

    // forwarding bundle toward execute
    typedef struct packed {
        logic       valid;
        logic [4:0] rd;
        rv32i_word  data;
    } fwd_t;

    // writeback record
    typedef struct packed {
        logic [4:0] rd;
        rv32i_word  data;
        logic       misaligned;
        mem_rec_t   mem;
    } wb_out_t;

endpackage

`default_nettype wire

/* hdl/lsu_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_top
    import rv32i_mem_pkg::*;
#(
    parameter int DEPTH_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    ex_valid,
    input  ex_mem_t ex_in,
    output logic    wb_valid,
    output wb_out_t wb_out,
    output fwd_t    fwd
);

    // word index bits the sram decodes
    localparam int ADDR_W = $clog2(DEPTH_WORDS);

    // sram port, full word index from the MEM stage
    logic [29:0] dmem_addr;
    logic        dmem_read;
    logic        dmem_write;
    logic [3:0]  dmem_byte_en;
    rv32i_word   dmem_wdata;
    rv32i_word   dmem_rdata;

    // MEM to WB
    logic        mem_wb_valid;
    mem_wb_t     mem_wb;

    mem_stage u_mem_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_in        (ex_in),
        .dmem_rdata   (dmem_rdata),
        .dmem_addr    (dmem_addr),
        .dmem_read    (dmem_read),
        .dmem_write   (dmem_write),
        .dmem_byte_en (dmem_byte_en),
        .dmem_wdata   (dmem_wdata),
        .fwd          (fwd),
        .mem_wb_valid (mem_wb_valid),
        .mem_wb       (mem_wb)
    );

    // upper index bits ignored, the space wraps
    data_sram #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_data_sram (
        .clk          (clk),
        .rst_n        (rst_n),
        .dmem_addr    (dmem_addr[ADDR_W-1:0]),
        .dmem_read    (dmem_read),
        .dmem_write   (dmem_write),
        .dmem_byte_en (dmem_byte_en),
        .dmem_wdata   (dmem_wdata),
        .dmem_rdata   (dmem_rdata)
    );

    wb_stage u_wb_stage (
        .mem_wb_valid (mem_wb_valid),
        .mem_wb       (mem_wb),
        .dmem_rdata   (dmem_rdata),
        .wb_valid     (wb_valid),
        .wb_out       (wb_out)
    );

endmodule

`default_nettype wire

/* hdl/wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_stage
    import rv32i_mem_pkg::*;
(
    input  logic      mem_wb_valid,
    input  mem_wb_t   mem_wb,
    // lands in the same cycle the MEM/WB register holds the load
    input  rv32i_word dmem_rdata,
    output logic      wb_valid,
    output wb_out_t   wb_out
);

    load_funct3_e load_f3;
    rv32i_word    lane;
    rv32i_word    load_val;
    rv32i_word    rdata_lanes;

    assign load_f3 = load_funct3_e'(mem_wb.funct3);

    // addressed byte or half moved down to bit 0
    assign lane = dmem_rdata >> {mem_wb.offset, 3'b000};

    // sign extension for lb and lh, zero for the unsigned forms
    always_comb begin
        case (load_f3)
            lb:      load_val = {{24{lane[7]}}, lane[7:0]};
            lbu:     load_val = {24'b0, lane[7:0]};
            lh:      load_val = {{16{lane[15]}}, lane[15:0]};
            lhu:     load_val = {16'b0, lane[15:0]};
            lw:      load_val = dmem_rdata;
            default: load_val = dmem_rdata;
        endcase
    end

    // record rdata keeps only the lanes the load read
    // an empty rmask, as for non-loads or misaligned loads, leaves zero
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdata_lanes[8*i +: 8] = mem_wb.mem.rmask[i] ? dmem_rdata[8*i +: 8] : 8'h00;
        end
    end

    // final regfile mux
    always_comb begin
        wb_out.rd         = mem_wb.rd;
        wb_out.misaligned = mem_wb.misaligned;
        wb_out.mem        = mem_wb.mem;
        wb_out.mem.rdata  = rdata_lanes;
        if (mem_wb.misaligned) begin
            // faulting access reports zero
            wb_out.data = '0;
        end else if (mem_wb.wb_sel == sel_mem) begin
            wb_out.data = load_val;
        end else begin
            wb_out.data = mem_wb.rd_data;
        end
    end

    // no work left that could hold the entry back
    assign wb_valid = mem_wb_valid;

endmodule

`default_nettype wire

/* mem/data_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_sram
    import rv32i_mem_pkg::*;
#(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [$clog2(DEPTH_WORDS)-1:0] dmem_addr,
    input  logic                           dmem_read,
    input  logic                           dmem_write,
    input  logic [3:0]                     dmem_byte_en,
    input  rv32i_word                      dmem_wdata,
    output rv32i_word                      dmem_rdata
);

    // four byte lanes per word
    logic [3:0][7:0] ram [DEPTH_WORDS];

    // per-lane write, lands at the edge after the strobe
    always_ff @(posedge clk) begin
        if (dmem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_byte_en[i]) begin
                    ram[dmem_addr][i] <= dmem_wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read, old contents on a same-edge write
    // value holds until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_rdata <= '0;
        end else if (dmem_read) begin
            dmem_rdata <= ram[dmem_addr];
        end
    end

    // index must fall inside the array on any access
    assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_read || dmem_write) |-> (dmem_addr < DEPTH_WORDS))
        else $error("data_sram: access beyond DEPTH_WORDS");

endmodule

`default_nettype wire

/* mem/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import rv32i_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ex_valid,
    input  ex_mem_t     ex_in,
    input  rv32i_word   dmem_rdata,
    // full word index, the top keeps only the bits the sram decodes
    output logic [29:0] dmem_addr,
    output logic        dmem_read,
    output logic        dmem_write,
    output logic [3:0]  dmem_byte_en,
    output rv32i_word   dmem_wdata,
    output fwd_t        fwd,
    output logic        mem_wb_valid,
    output mem_wb_t     mem_wb
);

    logic          ex_mem_valid;
    ex_mem_t       ex_mem;
    logic [1:0]    offset;
    load_funct3_e  load_f3;
    store_funct3_e store_f3;
    logic [3:0]    rmask;
    logic [3:0]    wmask;
    logic          misaligned;
    rv32i_word     lane_data;
    rv32i_word     rd_data;
    mem_rec_t      rec;
    mem_wb_t       mem_wb_d;

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_valid <= 1'b0;
        end else begin
            ex_mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            ex_mem <= ex_in;
        end
    end

    assign offset   = ex_mem.alu_out[1:0];
    assign load_f3  = load_funct3_e'(ex_mem.funct3);
    assign store_f3 = store_funct3_e'(ex_mem.funct3);

    // byte masks per width and offset
    // a misaligned access keeps both masks at zero
    always_comb begin
        rmask      = 4'b0000;
        wmask      = 4'b0000;
        misaligned = 1'b0;
        case (ex_mem.op)
            mop_store: begin
                case (store_f3)
                    sw: begin
                        if (offset == 2'b00) wmask = 4'b1111;
                        else misaligned = 1'b1;
                    end
                    sh: begin
                        if (!offset[0]) wmask = 4'b0011 << offset;
                        else misaligned = 1'b1;
                    end
                    sb: wmask = 4'b0001 << offset;
                    default: wmask = 4'b0000;
                endcase
            end
            mop_load: begin
                case (load_f3)
                    lw: begin
                        if (offset == 2'b00) rmask = 4'b1111;
                        else misaligned = 1'b1;
                    end
                    lh, lhu: begin
                        if (!offset[0]) rmask = 4'b0011 << offset;
                        else misaligned = 1'b1;
                    end
                    lb, lbu: rmask = 4'b0001 << offset;
                    default: rmask = 4'b0000;
                endcase
            end
            default: misaligned = 1'b0;
        endcase
    end

    // store data moved up into the lanes its mask names
    assign lane_data = ex_mem.store_data << {offset, 3'b000};

    // sram strobes, nothing goes out for an empty mask
    assign dmem_addr    = ex_mem.alu_out[31:2];
    assign dmem_read    = ex_mem_valid && (rmask != 4'b0000);
    assign dmem_write   = ex_mem_valid && (wmask != 4'b0000);
    assign dmem_byte_en = ex_mem_valid ? wmask : 4'b0000;
    assign dmem_wdata   = lane_data;

    // non-load result, shared by forwarding and writeback
    always_comb begin
        case (ex_mem.wb_sel)
            sel_alu:      rd_data = ex_mem.alu_out;
            sel_br_en:    rd_data = {31'b0, ex_mem.br_en};
            sel_u_imm:    rd_data = ex_mem.u_imm;
            sel_pc_plus4: rd_data = ex_mem.pc + 32'd4;
            default:      rd_data = ex_mem.alu_out;
        endcase
    end

    // load data is not here yet, so loads never forward from MEM
    assign fwd.valid = ex_mem_valid && (ex_mem.op != mop_load);
    assign fwd.rd    = ex_mem.rd;
    assign fwd.data  = rd_data;

    // memory record, wdata keeps only the written lanes
    always_comb begin
        rec       = ex_mem.mem;
        rec.addr  = {ex_mem.alu_out[31:2], 2'b00};
        rec.rmask = rmask;
        rec.wmask = wmask;
        // read port as seen now, wb replaces it once the load data lands
        rec.rdata = dmem_rdata;
        for (int i = 0; i < 4; i++) begin
            rec.wdata[8*i +: 8] = wmask[i] ? lane_data[8*i +: 8] : 8'h00;
        end
    end

    always_comb begin
        mem_wb_d.wb_sel     = ex_mem.wb_sel;
        mem_wb_d.funct3     = ex_mem.funct3;
        mem_wb_d.rd         = ex_mem.rd;
        mem_wb_d.pc         = ex_mem.pc;
        mem_wb_d.rd_data    = rd_data;
        mem_wb_d.offset     = offset;
        mem_wb_d.misaligned = misaligned;
        mem_wb_d.mem        = rec;
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb_valid <= 1'b0;
        end else begin
            mem_wb_valid <= ex_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_mem_valid) begin
            mem_wb <= mem_wb_d;
        end
    end

    // one port, one direction per cycle
    assert property (@(posedge clk) disable iff (!rst_n) !(dmem_read && dmem_write))
        else $error("mem_stage: read and write strobes high together");

    // no byte lane may be enabled outside a write
    assert property (@(posedge clk) disable iff (!rst_n) !dmem_write |-> dmem_byte_en == 4'b0000)
        else $error("mem_stage: byte enables set without a write");

endmodule

`default_nettype wire

/* sim/tb_lsu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_pipe
    import rv32i_mem_pkg::*;
();

    localparam int DEPTH_WORDS = 256;
    // items per phase, the timeout follows from their sum
    localparam int N_DIR_WORDS = 4;
    localparam int N_NONLOAD   = 32;
    localparam int N_MIS_WORDS = 2;
    localparam int N_RAND_WORDS = 8;
    localparam int N_RANDOM    = 200;
    localparam int N_ITEMS = N_DIR_WORDS * 46 + N_NONLOAD + N_MIS_WORDS * 13
                           + N_RAND_WORDS + N_RANDOM;
    localparam int CYCLE_LIMIT = 4 * N_ITEMS + 100;

    logic    clk;
    logic    rst_n;
    logic    ex_valid;
    ex_mem_t ex_in;
    logic    wb_valid;
    wb_out_t wb_out;
    fwd_t    fwd;

    // byte image of the sram, updated in issue order
    logic [7:0]  shadow [DEPTH_WORDS*4];
    wb_out_t     exp_q [$];
    wb_out_t     exp_head = '0;
    int          exp_count = 0;
    fwd_t        exp_fwd;
    logic [31:0] lcg_state = 32'd41559;
    logic        reset_seen = 1'b0;
    int          err_count = 0;
    int          issued = 0;
    int          wb_count = 0;
    int          cycle_count = 0;
    int          dir_words [N_DIR_WORDS] = '{3, 17, 64, 200};
    logic [2:0]  load_codes [5] = '{lb, lh, lw, lbu, lhu};

    lsu_pipe_top #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_valid (ex_valid),
        .ex_in    (ex_in),
        .wb_valid (wb_valid),
        .wb_out   (wb_out),
        .fwd      (fwd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[30:16]) % n;
    endfunction

    // upper halves only, the low LCG bits repeat too soon
    function rv32i_word rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};
    endfunction

    function void refresh_head();
        exp_count = exp_q.size();
        exp_head  = (exp_count > 0) ? exp_q[0] : '0;
    endfunction

    // builds the expected record, then drives one strobe
    task automatic issue(input mem_op_e op, input logic [2:0] f3, input wb_sel_e sel,
                         input rv32i_word addr, input rv32i_word sdata);
        ex_mem_t    item;
        wb_out_t    exp;
        fwd_t       f;
        logic [1:0] off;
        int         base;
        int         nbytes;
        int         lane;
        logic       mis;
        rv32i_word  value;
        rv32i_word  loaded;

        item            = '0;
        item.op         = op;
        item.funct3     = f3;
        item.wb_sel     = sel;
        item.rd         = 5'(next_rand() >> 16);
        item.pc         = rand_word() & 32'hFFFF_FFFC;
        item.alu_out    = addr;
        item.store_data = sdata;
        item.u_imm      = rand_word() & 32'hFFFF_F000;
        item.br_en      = 1'(next_rand() >> 31);
        case (sel)
            sel_br_en:    value = {31'b0, item.br_en};
            sel_u_imm:    value = item.u_imm;
            sel_pc_plus4: value = item.pc + 32'd4;
            default:      value = item.alu_out;
        endcase
        // width 1, 2 or 4 bytes from funct3[1:0]
        nbytes = 1 << f3[1:0];
        off    = addr[1:0];
        base   = int'(addr[9:2]) * 4;
        mis    = (op != mop_none) && ((int'(off) % nbytes) != 0);
        exp            = '0;
        exp.rd         = item.rd;
        exp.misaligned = mis;
        exp.mem.addr   = {addr[31:2], 2'b00};
        exp.data       = value;
        if (mis) begin
            exp.data = '0;
        end else if (op == mop_store) begin
            for (int i = 0; i < nbytes; i++) begin
                lane = off + i;
                exp.mem.wmask[lane]        = 1'b1;
                exp.mem.wdata[8*lane +: 8] = sdata[8*i +: 8];
                shadow[base + lane]        = sdata[8*i +: 8];
            end
        end else if (op == mop_load) begin
            loaded = '0;
            for (int i = 0; i < nbytes; i++) begin
                lane = off + i;
                exp.mem.rmask[lane]        = 1'b1;
                exp.mem.rdata[8*lane +: 8] = shadow[base + lane];
                loaded[8*i +: 8]           = shadow[base + lane];
            end
            // lb and lh carry the top loaded bit upward
            if (!f3[2]) begin
                for (int j = 8 * nbytes; j < 32; j++) begin
                    loaded[j] = loaded[8*nbytes-1];
                end
            end
            exp.data = loaded;
        end
        f.valid = (op != mop_load);
        f.rd    = item.rd;
        f.data  = value;
        @(posedge clk);
        #1;
        ex_in    = item;
        exp_fwd  = f;
        ex_valid = 1'b1;
        exp_q.push_back(exp);
        refresh_head();
        issued++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            ex_valid = 1'b0;
        end
    endtask

    // every legal load width and offset of one word
    task automatic load_sweep(input rv32i_word a);
        issue(mop_load, lw, sel_mem, a, '0);
        for (int o = 0; o < 4; o += 2) begin
            issue(mop_load, lh, sel_mem, a + o, '0);
            issue(mop_load, lhu, sel_mem, a + o, '0);
        end
        for (int o = 0; o < 4; o++) begin
            issue(mop_load, lb, sel_mem, a + o, '0);
            issue(mop_load, lbu, sel_mem, a + o, '0);
        end
    endtask

    // writeback retires the oldest expected record
    always @(posedge clk) begin
        if (!rst_n) reset_seen <= 1'b1;
        if (rst_n && wb_valid) begin
            wb_count++;
            if (exp_q.size() > 0) begin
                exp_q.delete(0);
                refresh_head();
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> exp_count > 0)
        else begin
            err_count++;
            $display("writeback arrived with no instruction outstanding at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid && exp_count > 0) |-> wb_out == exp_head)
        else begin
            err_count++;
            $display("error %0t: writeback rd %0d data %h mis %b mem %h", $time,
                $sampled(wb_out.rd), $sampled(wb_out.data), $sampled(wb_out.misaligned),
                $sampled(wb_out.mem));
            $display("error %0t: expected rd %0d data %h mis %b mem %h", $time,
                $sampled(exp_head.rd), $sampled(exp_head.data),
                $sampled(exp_head.misaligned), $sampled(exp_head.mem));
        end

    // fixed two cycle latency, back to back included
    assert property (@(posedge clk) disable iff (!rst_n) wb_valid == $past(ex_valid, 2))
        else begin
            err_count++;
            $display("writeback strobe out of step with the issue two cycles back at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        fwd.valid == ($past(ex_valid) && $past(exp_fwd.valid)))
        else begin
            err_count++;
            $display("forwarding strobe wrong one cycle after issue at %0t", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        fwd.valid |-> (fwd.rd == $past(exp_fwd.rd) && fwd.data == $past(exp_fwd.data)))
        else begin
            err_count++;
            $display("error %0t: forward rd %0d data %h, expected rd %0d data %h", $time,
                $sampled(fwd.rd), $sampled(fwd.data), $past(exp_fwd.rd), $past(exp_fwd.data));
        end

    // quiet during reset and for two edges after release
    assert property (@(posedge clk)
        (reset_seen && (!rst_n || !$past(rst_n, 2))) |-> (!wb_valid && !fwd.valid))
        else begin
            err_count++;
            $display("valid output high during or right after reset at %0t", $time);
        end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with writebacks still missing", CYCLE_LIMIT);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rv32i_word a;
        int        kind;
        int        off;

        rst_n    = 1'b0;
        ex_valid = 1'b0;
        ex_in    = '0;
        exp_fwd  = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(2);
        // stores of each width, each followed at once by every load
        for (int w = 0; w < N_DIR_WORDS; w++) begin
            a = dir_words[w] * 4;
            issue(mop_store, sw, sel_alu, a, rand_word());
            load_sweep(a);
            issue(mop_store, sh, sel_alu, a, rand_word());
            issue(mop_store, sh, sel_alu, a + 2, rand_word());
            load_sweep(a);
            for (int o = 0; o < 4; o++) issue(mop_store, sb, sel_alu, a + o, rand_word());
            load_sweep(a);
        end
        // non-load selects with random gaps
        for (int i = 0; i < N_NONLOAD; i++) begin
            issue(mop_none, 3'(rand_below(8)), wb_sel_e'(i % 4), rand_word(), rand_word());
            idle(rand_below(3));
        end
        // misaligned accesses, then an aligned lw shows the word untouched
        for (int w = 0; w < N_MIS_WORDS; w++) begin
            a = dir_words[w] * 4;
            for (int o = 1; o < 4; o++) issue(mop_store, sw, sel_alu, a + o, rand_word());
            for (int o = 1; o < 4; o += 2) issue(mop_store, sh, sel_alu, a + o, rand_word());
            for (int o = 1; o < 4; o++) issue(mop_load, lw, sel_mem, a + o, '0);
            issue(mop_load, lh, sel_mem, a + 1, '0);
            issue(mop_load, lhu, sel_mem, a + 3, '0);
            issue(mop_load, lh, sel_mem, a + 3, '0);
            issue(mop_load, lhu, sel_mem, a + 1, '0);
            issue(mop_load, lw, sel_mem, a, '0);
        end
        // random mix back to back, upper address bits wrap
        for (int w = 0; w < N_RAND_WORDS; w++) begin
            issue(mop_store, sw, sel_alu, (96 + w) * 4, rand_word());
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            kind = rand_below(3);
            off  = rand_below(4);
            a    = (rand_word() & 32'hFFFF_FC00) | ((96 + rand_below(N_RAND_WORDS)) * 4) | off;
            if (kind == 0) issue(mop_store, 3'(rand_below(3)), sel_alu, a, rand_word());
            else if (kind == 1) issue(mop_load, load_codes[rand_below(5)], sel_mem, a, '0);
            else issue(mop_none, 3'(rand_below(8)), wb_sel_e'(rand_below(4)), a, rand_word());
        end
        idle(1);
        wait (exp_count == 0);
        idle(2);
        if (wb_count != issued) begin
            err_count++;
            $display("%0d writebacks seen for %0d issued instructions", wb_count, issued);
        end
        $display("summary: %0d issued, %0d written back, %0d errors", issued, wb_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
common/rv32i_mem_pkg.sv
mem/mem_stage.sv
mem/data_sram.sv
hdl/wb_stage.sv
hdl/lsu_pipe_top.sv
sim/tb_lsu_pipe.sv
